//--- Bender.yml
package:
  name: dual_issue_core

sources:
  - include_dirs:
      - .
    files:
      - issue_pkg.sv
      - issue_if.sv
      - inst_queue.sv
      - score_board.sv
      - issue.sv
      - alu_lane.sv
      - retire_unit.sv
      - dual_issue_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_dual_issue.sv

//--- alu_lane.sv
`timescale 1ns/10ps
`include "issue_cfg.svh"

module alu_lane import issue_pkg::*; (
    input  logic clk,
    input  logic rst,
    fu_if.sink   fu,
    wb_if.source wb
);

    localparam int SHW = $clog2(`DATA_W);

    data_t           result_d;
    logic [SHW-1:0]  shamt;

    assign shamt = fu.req.b[SHW-1:0]; // low bits of b only

    always_comb begin
        result_d = '0;
        unique case (fu.req.op)
            op_add: result_d = fu.req.a + fu.req.b;
            op_sub: result_d = fu.req.a - fu.req.b;
            op_and: result_d = fu.req.a & fu.req.b;
            op_or:  result_d = fu.req.a | fu.req.b;
            op_xor: result_d = fu.req.a ^ fu.req.b;
            op_sll: result_d = fu.req.a << shamt;
            op_srl: result_d = fu.req.a >> shamt;
            op_slt: result_d = data_t'($signed(fu.req.a) < $signed(fu.req.b));
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= fu.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fu.valid) begin
            wb.rd     <= fu.req.rd;
            wb.result <= result_d;
        end
    end

endmodule

//--- compile.f
+incdir+.
issue_pkg.sv
issue_if.sv
inst_queue.sv
score_board.sv
issue.sv
alu_lane.sv
retire_unit.sv
dual_issue_core.sv
tb_dual_issue.sv

//--- dual_issue_core.sv
`timescale 1ns/10ps
`include "issue_cfg.svh"

module dual_issue_core import issue_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    in_valid,
    input  inst_t                   in_inst,
    output logic                    in_ready,
    output logic [1:0]              retire_valid,
    output logic [1:0][`REG_AW-1:0] retire_rd,
    output logic [1:0][`DATA_W-1:0] retire_data
);

    logic [1:0]      head_valid;
    inst_t [1:0]     head_inst;
    logic [1:0]      pop_count;
    reg_addr_t [3:0] sb_rd_addr;
    logic [3:0]      sb_pending;
    reg_addr_t [1:0] dest_addr;
    logic [1:0]      dest_pending;
    logic [1:0]      set_en;
    reg_addr_t [1:0] set_addr;
    reg_addr_t [3:0] rf_addr;
    data_t [3:0]     rf_data;

    fu_if fu [2] ();
    wb_if wb [2] ();

    inst_queue u_inst_queue (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .push_valid (in_valid),
        .push_inst  (in_inst),
        .push_ready (in_ready),
        .head_valid (head_valid),
        .head_inst  (head_inst),
        .pop_count  (pop_count)
    );

    issue u_issue (
        .head_valid   (head_valid),
        .head_inst    (head_inst),
        .pop_count    (pop_count),
        .rd_addr      (sb_rd_addr),
        .pending      (sb_pending),
        .dest_addr    (dest_addr),
        .dest_pending (dest_pending),
        .set_en       (set_en),
        .set_addr     (set_addr),
        .rf_addr      (rf_addr),
        .rf_data      (rf_data),
        .flush        (flush),
        .fu0          (fu[0]),
        .fu1          (fu[1])
    );

    score_board u_score_board (
        .clk          (clk),
        .rst          (rst),
        .rd_addr      (sb_rd_addr),
        .pending      (sb_pending),
        .dest_addr    (dest_addr),
        .dest_pending (dest_pending),
        .set_en       (set_en),
        .set_addr     (set_addr),
        .wb0          (wb[0]),
        .wb1          (wb[1])
    );

    for (genvar g = 0; g < 2; g++) begin : g_lane
        alu_lane u_alu_lane (
            .clk (clk),
            .rst (rst),
            .fu  (fu[g]),
            .wb  (wb[g])
        );
    end

    retire_unit u_retire_unit (
        .clk          (clk),
        .rst          (rst),
        .rf_addr      (rf_addr),
        .rf_data      (rf_data),
        .wb0          (wb[0]),
        .wb1          (wb[1]),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

endmodule

//--- inst_queue.sv
`timescale 1ns/10ps
`include "issue_cfg.svh"

module inst_queue import issue_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        push_valid,
    input  inst_t       push_inst,
    output logic        push_ready,
    output logic [1:0]  head_valid,
    output inst_t [1:0] head_inst,
    input  logic [1:0]  pop_count
);

    localparam int AW = $clog2(`IQ_DEPTH);
    localparam int CW = AW + 1;

    inst_t          mem [`IQ_DEPTH];
    logic [AW-1:0]  rd_ptr;
    logic [AW-1:0]  wr_ptr;
    logic [CW-1:0]  count;
    logic           push_fire;

    // no push into a full queue, even if it pops this cycle
    assign push_ready = (count != CW'(`IQ_DEPTH));
    assign push_fire  = push_valid && push_ready;

    always_ff @(posedge clk) begin
        if (push_fire) begin
            mem[wr_ptr] <= push_inst;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (flush) begin
                // drop everything older, keep a same-cycle push
                rd_ptr <= wr_ptr;
                count  <= CW'(push_fire);
            end else begin
                rd_ptr <= rd_ptr + AW'(pop_count);
                count  <= count + CW'(push_fire) - CW'(pop_count);
            end
        end
    end

    // two oldest entries, pointer wraps naturally
    assign head_inst[0]  = mem[rd_ptr];
    assign head_inst[1]  = mem[rd_ptr + 1'b1];
    assign head_valid[0] = (count != '0);
    assign head_valid[1] = (count > CW'(1));

endmodule

//--- issue.sv
`timescale 1ns/10ps

module issue import issue_pkg::*; (
    input  logic [1:0]      head_valid,
    input  inst_t [1:0]     head_inst,
    output logic [1:0]      pop_count,
    output reg_addr_t [3:0] rd_addr,
    input  logic [3:0]      pending,
    output reg_addr_t [1:0] dest_addr,
    input  logic [1:0]      dest_pending,
    output logic [1:0]      set_en,
    output reg_addr_t [1:0] set_addr,
    output reg_addr_t [3:0] rf_addr,
    input  data_t [3:0]     rf_data,
    input  logic            flush,
    fu_if.source            fu0,
    fu_if.source            fu1
);

    reg_addr_t [3:0] src_addr; // h0.rs1, h0.rs2, h1.rs1, h1.rs2
    logic [3:0]      src_used;
    logic [3:0]      src_ok;
    logic [1:0]      head_ready;
    logic            pair_raw;
    logic            pair_waw;
    logic            issue0;
    logic            issue1;

    function automatic fu_req_t build_req(inst_t inst, data_t rs1_val, data_t rs2_val);
        fu_req_t req;
        req.op = inst.op;
        req.a  = rs1_val;
        req.b  = inst.use_imm ? inst.imm : rs2_val;
        req.rd = inst.rd;
        return req;
    endfunction

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            src_addr[2*i]   = head_inst[i].rs1;
            src_addr[2*i+1] = head_inst[i].rs2;
            src_used[2*i]   = 1'b1;
            src_used[2*i+1] = !head_inst[i].use_imm;
            dest_addr[i]    = head_inst[i].rd;
        end
    end

    assign rd_addr = src_addr;
    assign rf_addr = src_addr;

    // no bypass, a source is ready only once written back
    always_comb begin
        for (int j = 0; j < 4; j++) begin
            src_ok[j] = !src_used[j] || src_addr[j] == '0 || !pending[j];
        end
        for (int i = 0; i < 2; i++) begin
            head_ready[i] = src_ok[2*i] && src_ok[2*i+1] && !dest_pending[i];
        end
    end

    // hazards inside the pair, scoreboard does not see them yet
    assign pair_raw = head_inst[0].rd != '0 &&
                      (head_inst[1].rs1 == head_inst[0].rd ||
                       (src_used[3] && head_inst[1].rs2 == head_inst[0].rd));
    assign pair_waw = head_inst[1].rd == head_inst[0].rd;

    // in order, head 1 only behind head 0
    assign issue0 = !flush && head_valid[0] && head_ready[0];
    assign issue1 = issue0 && head_valid[1] && head_ready[1] && !pair_raw && !pair_waw;

    assign pop_count = {1'b0, issue0} + {1'b0, issue1};

    assign set_en   = {issue1, issue0};
    assign set_addr = {head_inst[1].rd, head_inst[0].rd};

    assign fu0.valid = issue0;
    assign fu0.req   = build_req(head_inst[0], rf_data[0], rf_data[1]);
    assign fu1.valid = issue1;
    assign fu1.req   = build_req(head_inst[1], rf_data[2], rf_data[3]);

endmodule

//--- issue_cfg.svh
`ifndef ISSUE_CFG_SVH
`define ISSUE_CFG_SVH

// operand and result width
`define DATA_W 32

// architectural register file
`define NUM_REGS 32
`define REG_AW 5

// instruction queue entries, power of two
`define IQ_DEPTH 8

`endif

//--- issue_if.sv
`timescale 1ns/10ps

// issue to alu lane, lane always accepts
interface fu_if import issue_pkg::*; ();

    logic    valid;
    fu_req_t req;

    modport source (
        output valid,
        output req
    );

    modport sink (
        input valid,
        input req
    );

endinterface

// lane result towards register file and scoreboard
interface wb_if import issue_pkg::*; ();

    logic      valid;
    reg_addr_t rd;
    data_t     result;

    modport source (
        output valid,
        output rd,
        output result
    );

    modport sink (
        input valid,
        input rd,
        input result
    );

endinterface

//--- issue_pkg.sv
`include "issue_cfg.svh"

package issue_pkg;

    typedef logic [`DATA_W-1:0] data_t;
    typedef logic [`REG_AW-1:0] reg_addr_t;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_sll,
        op_srl,
        op_slt
    } alu_op_e;

    typedef struct packed {
        alu_op_e   op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      use_imm; // b from imm
        data_t     imm;
    } inst_t;

    // operands already resolved at issue
    typedef struct packed {
        alu_op_e   op;
        data_t     a;
        data_t     b;
        reg_addr_t rd;
    } fu_req_t;

    typedef logic [`NUM_REGS-1:0] pend_vec_t; // one bit per register

endpackage

//--- retire_unit.sv
`timescale 1ns/10ps
`include "issue_cfg.svh"

module retire_unit import issue_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  reg_addr_t [3:0] rf_addr,
    output data_t [3:0]     rf_data,
    wb_if.sink              wb0,
    wb_if.sink              wb1,
    output logic [1:0]      retire_valid,
    output reg_addr_t [1:0] retire_rd,
    output data_t [1:0]     retire_data
);

    data_t regs [`NUM_REGS];

    // r0 is cleared by reset and never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb0.valid && wb0.rd != '0) begin
                regs[wb0.rd] <= wb0.result;
            end
            if (wb1.valid && wb1.rd != '0) begin
                regs[wb1.rd] <= wb1.result; // lane 1 wins
            end
        end
    end

    always_comb begin
        for (int j = 0; j < 4; j++) begin
            rf_data[j] = regs[rf_addr[j]];
        end
    end

    // lane 0 holds the older one
    assign retire_valid = {wb1.valid, wb0.valid};
    assign retire_rd    = {wb1.rd, wb0.rd};
    assign retire_data  = {wb1.result, wb0.result};

endmodule

//--- score_board.sv
`timescale 1ns/10ps
`include "issue_cfg.svh"

module score_board import issue_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [3:0][`REG_AW-1:0] rd_addr,
    output logic [3:0]             pending,
    input  logic [1:0][`REG_AW-1:0] dest_addr,
    output logic [1:0]             dest_pending,
    input  logic [1:0]             set_en,
    input  logic [1:0][`REG_AW-1:0] set_addr,
    wb_if.sink                     wb0,
    wb_if.sink                     wb1
);

    pend_vec_t pend;
    pend_vec_t pend_set;
    pend_vec_t pend_clr;

    always_comb begin
        pend_set = '0;
        pend_clr = '0;
        for (int i = 0; i < 2; i++) begin
            if (set_en[i] && set_addr[i] != '0) begin // r0 never pending
                pend_set[set_addr[i]] = 1'b1;
            end
        end
        if (wb0.valid) pend_clr[wb0.rd] = 1'b1;
        if (wb1.valid) pend_clr[wb1.rd] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pend <= '0;
        end else begin
            pend <= (pend & ~pend_clr) | pend_set; // set wins
        end
    end

    always_comb begin
        for (int j = 0; j < 4; j++) pending[j] = pend[rd_addr[j]];
        for (int k = 0; k < 2; k++) dest_pending[k] = pend[dest_addr[k]];
    end

endmodule

//--- tb_dual_issue.sv
`timescale 1ns/10ps
`include "issue_cfg.svh"

module tb_dual_issue import issue_pkg::*; ();

    localparam int CLK_PERIOD = 10;
    localparam int MAX_CYCLES = 2000;

    logic                    clk;
    logic                    rst;
    logic                    flush;
    logic                    in_valid;
    inst_t                   in_inst;
    logic                    in_ready;
    logic [1:0]              retire_valid;
    logic [1:0][`REG_AW-1:0] retire_rd;
    logic [1:0][`DATA_W-1:0] retire_data;

    data_t  model_regs [`NUM_REGS]; // updated from observed retires only
    inst_t  exp_q [$];              // accepted, not yet retired
    string  cur_test = "reset";
    int     seed = 32'h5bc0_e0a3;
    int     cycle_cnt = 0;
    int     dual_cnt = 0;
    logic   stall_seen = 1'b0;
    time    last_ret_time = 0;

    dual_issue_core u_dual_issue_core (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .in_valid     (in_valid),
        .in_inst      (in_inst),
        .in_ready     (in_ready),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run exceeded %0d cycles in test %s", MAX_CYCLES, cur_test);
            $display("FAIL: see errors above");
            $fatal(1, "simulation timeout");
        end
    end

    task automatic check_eq(input string what, input logic [63:0] expected,
                            input logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERROR test=%s %s expected=%0h actual=%0h", cur_test, what, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic data_t expected_alu(alu_op_e op, data_t a, data_t b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_sll:  return a << b[4:0];
            op_srl:  return a >> b[4:0];
            op_slt:  return ($signed(a) < $signed(b)) ? data_t'(1) : data_t'(0);
            default: return '0;
        endcase
    endfunction

    function automatic inst_t make_inst(alu_op_e op, int rd, int rs1, int rs2,
                                        logic use_imm, data_t imm);
        inst_t inst;
        inst.op      = op;
        inst.rd      = reg_addr_t'(rd);
        inst.rs1     = reg_addr_t'(rs1);
        inst.rs2     = reg_addr_t'(rs2);
        inst.use_imm = use_imm;
        inst.imm     = imm;
        return inst;
    endfunction

    // pair each retire with the oldest outstanding instruction, lane 0 first
    always @(posedge clk) begin
        inst_t inst;
        data_t a;
        data_t b;
        if (!rst) begin
            if (retire_valid == 2'b11) dual_cnt++;
            for (int l = 0; l < 2; l++) begin
                if (retire_valid[l] && exp_q.size() == 0) begin
                    $display("retire with no instruction outstanding in test %s", cur_test);
                    $display("FAIL: see errors above");
                    $fatal(1, "unexpected retire");
                end else if (retire_valid[l]) begin
                    inst = exp_q.pop_front();
                    a = model_regs[inst.rs1];
                    b = inst.use_imm ? inst.imm : model_regs[inst.rs2];
                    check_eq("retire rd", inst.rd, retire_rd[l]);
                    check_eq("retire data", expected_alu(inst.op, a, b), retire_data[l]);
                    if (inst.rd != '0) model_regs[inst.rd] = retire_data[l];
                    last_ret_time = $time;
                end
            end
        end
    end

    // holds in_valid high until accepted
    task automatic push_inst(input inst_t inst);
        in_valid <= 1'b1;
        in_inst  <= inst;
        @(posedge clk);
        while (!in_ready) begin
            stall_seen = 1'b1;
            @(posedge clk);
        end
        exp_q.push_back(inst);
    endtask

    task automatic wait_for_retires();
        in_valid <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        repeat (3) @(posedge clk);
    endtask

    task automatic independent_ops_test();
        int dual_start;
        cur_test = "independent";
        dual_start = dual_cnt;
        for (int i = 1; i <= 8; i++) begin
            push_inst(make_inst(op_add, i, 0, 0, 1'b1, data_t'($random(seed))));
        end
        // first op waits on the last load, so the next op pairs with it
        for (int k = 0; k < 8; k++) begin
            push_inst(make_inst(alu_op_e'(k), 9 + k, 8 - k, 1 + (k + 3) % 8, 1'b0, '0));
        end
        wait_for_retires();
        check_eq("dual retire seen", 1, dual_cnt > dual_start);
    endtask

    task automatic dependent_chain_test();
        int dual_start;
        cur_test = "chain";
        dual_start = dual_cnt;
        for (int k = 0; k < 10; k++) begin
            push_inst(make_inst(alu_op_e'(k % 8), 17 + k, (k == 0) ? 1 : 16 + k, 2,
                                k[0], data_t'($random(seed))));
        end
        wait_for_retires();
        check_eq("same cycle chain retires", 0, dual_cnt - dual_start);
    endtask

    task automatic reg_zero_test();
        data_t last_val;
        cur_test = "reg_zero";
        last_val = data_t'($random(seed));
        push_inst(make_inst(op_add, 0, 0, 0, 1'b1, 32'hdead_beef)); // r0 write retires
        push_inst(make_inst(op_or, 5, 0, 0, 1'b0, '0));
        push_inst(make_inst(op_add, 6, 0, 0, 1'b1, 32'd7));
        push_inst(make_inst(op_add, 7, 0, 0, 1'b1, data_t'($random(seed)))); // waw pair
        push_inst(make_inst(op_add, 7, 0, 0, 1'b1, last_val));
        push_inst(make_inst(op_or, 8, 7, 0, 1'b0, '0));
        wait_for_retires();
        check_eq("r5 from r0", 0, model_regs[5]);
        check_eq("waw final r7", last_val, model_regs[7]);
        check_eq("read after waw", last_val, model_regs[8]);
    endtask

    task automatic backpressure_test();
        cur_test = "backpressure";
        stall_seen = 1'b0;
        for (int k = 0; k < 20; k++) begin
            push_inst(make_inst(op_add, 10 + k % 2, 10 + (k + 1) % 2, 0, 1'b1,
                                data_t'($random(seed))));
        end
        wait_for_retires();
        check_eq("in_ready fell", 1, stall_seen);
    endtask

    task automatic flush_test();
        time flush_time;
        cur_test = "flush";
        for (int k = 0; k < 8; k++) begin
            push_inst(make_inst(op_add, 17 + k, (k == 0) ? 1 : 16 + k, 0, 1'b1, data_t'(k + 1)));
        end
        in_valid <= 1'b0;
        flush    <= 1'b1;
        @(posedge clk);
        flush_time = $time;
        flush <= 1'b0;
        repeat (4) @(posedge clk);
        check_eq("late retire after flush", 1, last_ret_time <= flush_time + 2 * CLK_PERIOD);
        exp_q.delete(); // flushed chain tail never retires
        for (int i = 1; i <= 4; i++) begin
            push_inst(make_inst(op_add, 26 + i, 0, 0, 1'b1, data_t'($random(seed))));
        end
        push_inst(make_inst(op_xor, 31, 27, 28, 1'b0, '0));
        push_inst(make_inst(op_sub, 30, 29, 30, 1'b0, '0));
        wait_for_retires();
    endtask

    initial begin
        rst      = 1'b1;
        flush    = 1'b0;
        in_valid = 1'b0;
        in_inst  = '0;
        for (int i = 0; i < `NUM_REGS; i++) model_regs[i] = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_eq("in_ready after reset", 1, in_ready);
        check_eq("retire_valid after reset", 0, retire_valid);
        independent_ops_test();
        dependent_chain_test();
        reg_zero_test();
        backpressure_test();
        flush_test();
        $display("PASS: all tests");
        $finish;
    end

endmodule
